// File: build.f
+incdir+test
logic/pu_cfg_pkg.sv
logic/reg_access_if.sv
logic/cfg_addr_decoder.sv
logic/cfg_write_channel.sv
logic/cfg_read_channel.sv
logic/policy_reg_file.sv
logic/protection_cfg_top.sv
test/tb_protection_cfg.sv

// File: test/tb_cfg_tasks.svh
`ifndef TB_CFG_TASKS_SVH
`define TB_CFG_TASKS_SVH

// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
function automatic logic [31:0] next_random_word();
  logic [31:0] w = '0;
  logic        fb;
  for (int i = 0; i < 32; i++)
  begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    w          = {w[30:0], fb};
  end
  return w;
endfunction

// Byte lanes with a strobe take the new data
function automatic logic [CFG_DATA_W-1:0] merge_strobed(input logic [CFG_DATA_W-1:0] old_word,
                                                        input logic [CFG_DATA_W-1:0] new_word,
                                                        input logic [CFG_STRB_W-1:0] strb);
  logic [CFG_DATA_W-1:0] w = old_word;
  for (int b = 0; b < CFG_STRB_W; b++)
  begin
    if (strb[b])
      w[8*b +: 8] = new_word[8*b +: 8];
  end
  return w;
endfunction

// Domain d reads bit 2d+1 as rd and bit 2d as wr
function automatic region_policy_t entries_of(input logic [CFG_DATA_W-1:0] word);
  region_policy_t e;
  for (int d = 0; d < TB_DOMAINS; d++)
  begin
    e[d].rd = word[2*d+1];
    e[d].wr = word[2*d];
  end
  return e;
endfunction

task automatic check_word(input logic [CFG_DATA_W-1:0] act, input logic [CFG_DATA_W-1:0] exp,
                          input string what);
  if (act !== exp)
  begin
    $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, act, exp);
    fail_run();
  end
endtask

task automatic check_resp(input logic [1:0] act, input logic [1:0] exp, input string what);
  if (act !== exp)
  begin
    $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, act, exp);
    fail_run();
  end
endtask

task automatic check_bit(input logic act, input logic exp, input string what);
  if (act !== exp)
  begin
    $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, act, exp);
    fail_run();
  end
endtask

task automatic check_policy(input region_policy_t act, input region_policy_t exp, input int region);
  if (act !== exp)
  begin
    $display("FAILED at %0d ns: policy_o of region %0d is %b, expected %b",
             $time, region, act, exp);
    fail_run();
  end
endtask

// Counts one more cycle of waiting and gives up past the limit
task automatic count_wait(inout int n, input string what);
  n++;
  if (n > TIMEOUT_CYCLES)
  begin
    $display("Timeout: %s did not rise within %0d cycles", what, TIMEOUT_CYCLES);
    fail_run();
  end
endtask

// Starts on a falling edge and returns on the falling edge after the AW/W handshake
task automatic send_write(input logic [CFG_ADDR_W-1:0] addr, input logic [2:0] prot,
                          input logic [CFG_DATA_W-1:0] data, input logic [CFG_STRB_W-1:0] strb);
  int n = 0;
  aw_addr_i  = addr;
  aw_prot_i  = prot;
  w_data_i   = data;
  w_strb_i   = strb;
  aw_valid_i = 1'b1;
  w_valid_i  = 1'b1;
  // Readies are combinational and settle just after the inputs
  #1;
  while (!aw_ready_o)
  begin
    count_wait(n, "aw_ready_o");
    @(negedge clk_i);
    #1;
  end
  check_bit(w_ready_o, 1'b1, "w_ready_o together with aw_ready_o");
  @(negedge clk_i);
  aw_valid_i = 1'b0;
  w_valid_i  = 1'b0;
endtask

// B outputs come from flops and are stable on the falling edge
task automatic take_write_resp(output logic [1:0] resp);
  int n = 0;
  while (!b_valid_o)
  begin
    count_wait(n, "b_valid_o");
    @(negedge clk_i);
  end
  resp      = b_resp_o;
  b_ready_i = 1'b1;
  @(negedge clk_i);
  b_ready_i = 1'b0;
endtask

task automatic send_read(input logic [CFG_ADDR_W-1:0] addr, input logic [2:0] prot);
  int n = 0;
  ar_addr_i  = addr;
  ar_prot_i  = prot;
  ar_valid_i = 1'b1;
  #1;
  while (!ar_ready_o)
  begin
    count_wait(n, "ar_ready_o");
    @(negedge clk_i);
    #1;
  end
  @(negedge clk_i);
  ar_valid_i = 1'b0;
endtask

task automatic take_read_resp(output logic [CFG_DATA_W-1:0] data, output logic [1:0] resp);
  int n = 0;
  while (!r_valid_o)
  begin
    count_wait(n, "r_valid_o");
    @(negedge clk_i);
  end
  data      = r_data_o;
  resp      = r_resp_o;
  r_ready_i = 1'b1;
  @(negedge clk_i);
  r_ready_i = 1'b0;
endtask

task automatic write_word(input logic [CFG_ADDR_W-1:0] addr, input logic [2:0] prot,
                          input logic [CFG_DATA_W-1:0] data, input logic [CFG_STRB_W-1:0] strb,
                          input logic [1:0] exp_resp);
  logic [1:0] resp;
  send_write(addr, prot, data, strb);
  take_write_resp(resp);
  check_resp(resp, exp_resp, $sformatf("b_resp_o for write to %h", addr));
endtask

task automatic read_word(input logic [CFG_ADDR_W-1:0] addr, input logic [2:0] prot,
                         input logic [CFG_DATA_W-1:0] exp_data, input logic [1:0] exp_resp);
  logic [CFG_DATA_W-1:0] data;
  logic [1:0]            resp;
  send_read(addr, prot);
  take_read_resp(data, resp);
  check_resp(resp, exp_resp, $sformatf("r_resp_o for read of %h", addr));
  check_word(data, exp_data, $sformatf("r_data_o for read of %h", addr));
endtask

`endif

// File: test/tb_protection_cfg.sv
`timescale 1ns/1ps

module tb_protection_cfg;
  import pu_cfg_pkg::*;

  localparam int unsigned TB_REGIONS     = 4;
  localparam int unsigned TB_DOMAINS     = 3;
  localparam int unsigned CLK_PERIOD     = 40;
  localparam int unsigned TIMEOUT_CYCLES = 16;
  // Only the bits of existing domains survive a write
  localparam logic [CFG_DATA_W-1:0] POLICY_MASK = (32'd1 << (2 * TB_DOMAINS)) - 1;
  localparam logic [2:0] PRIV = 3'b001;

  typedef policy_entry_t [TB_DOMAINS-1:0] region_policy_t;

  logic                  clk_i;
  logic                  reset_i;
  logic                  aw_valid_i;
  logic                  aw_ready_o;
  logic [CFG_ADDR_W-1:0] aw_addr_i;
  logic [2:0]            aw_prot_i;
  logic                  w_valid_i;
  logic                  w_ready_o;
  logic [CFG_DATA_W-1:0] w_data_i;
  logic [CFG_STRB_W-1:0] w_strb_i;
  logic                  b_valid_o;
  logic                  b_ready_i;
  logic [1:0]            b_resp_o;
  logic                  ar_valid_i;
  logic                  ar_ready_o;
  logic [CFG_ADDR_W-1:0] ar_addr_i;
  logic [2:0]            ar_prot_i;
  logic                  r_valid_o;
  logic                  r_ready_i;
  logic [CFG_DATA_W-1:0] r_data_o;
  logic [1:0]            r_resp_o;
  logic [CFG_DATA_W-1:0] ctrl_o;
  policy_entry_t [TB_REGIONS-1:0][TB_DOMAINS-1:0] policy_o;

  // Expected register contents
  logic [CFG_DATA_W-1:0] ctrl_model;
  logic [CFG_DATA_W-1:0] pol_model [TB_REGIONS];
  logic [31:0]           lfsr_state = 32'hb9457fd1;

  protection_cfg_top #(
    .NUM_REGIONS    (TB_REGIONS),
    .NUM_DOMAINS    (TB_DOMAINS),
    .PRIV_PROT_ONLY (1'b1),
    .SECU_PROT_ONLY (1'b0)
  ) UUT (
    .clk_i, .reset_i, .aw_valid_i, .aw_ready_o, .aw_addr_i, .aw_prot_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i, .b_valid_o, .b_ready_i, .b_resp_o,
    .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_prot_i,
    .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o, .ctrl_o, .policy_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  `include "tb_cfg_tasks.svh"

  function automatic logic [CFG_ADDR_W-1:0] region_addr(input int r);
    return POLICY_BASE + CFG_ADDR_W'(4 * r);
  endfunction

  // Outputs and read-back of every mapped word against the models
  task automatic check_all_regs();
    check_word(ctrl_o, ctrl_model, "ctrl_o");
    read_word(CTRL_OFFSET, PRIV, ctrl_model, RESP_OKAY);
    for (int r = 0; r < TB_REGIONS; r++)
    begin
      read_word(region_addr(r), PRIV, pol_model[r], RESP_OKAY);
      check_policy(policy_o[r], entries_of(pol_model[r]), r);
    end
  endtask

  // Entered on the falling edge where reset drops
  task automatic test_reset();
    aw_addr_i  = 7'h04;
    aw_prot_i  = PRIV;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    #1;
    check_bit(aw_ready_o, 1'b0, "aw_ready_o in first cycle after reset");
    check_bit(w_ready_o, 1'b0, "w_ready_o in first cycle after reset");
    check_bit(ar_ready_o, 1'b0, "ar_ready_o in first cycle after reset");
    check_bit(b_valid_o, 1'b0, "b_valid_o in first cycle after reset");
    check_bit(r_valid_o, 1'b0, "r_valid_o in first cycle after reset");
    @(negedge clk_i);
    // Pending request to an unmapped word goes through once readies rise
    write_word(7'h04, PRIV, '0, '0, RESP_SLVERR);
    check_all_regs();
  endtask

  task automatic test_ctrl_strobes();
    logic [2:0][CFG_STRB_W-1:0] strbs = {4'b0011, 4'b1000, 4'b0101};
    logic [CFG_DATA_W-1:0]      data;
    for (int i = 0; i < 3; i++)
    begin
      data = next_random_word();
      write_word(CTRL_OFFSET, PRIV, data, strbs[i], RESP_OKAY);
      ctrl_model = merge_strobed(ctrl_model, data, strbs[i]);
      check_word(ctrl_o, ctrl_model, "ctrl_o after strobed write");
      read_word(CTRL_OFFSET, PRIV, ctrl_model, RESP_OKAY);
    end
  endtask

  task automatic test_policy_writes();
    logic [CFG_DATA_W-1:0] data;
    for (int r = 0; r < TB_REGIONS; r++)
    begin
      data = next_random_word();
      write_word(region_addr(r), PRIV, data, 4'hF, RESP_OKAY);
      pol_model[r] = data & POLICY_MASK;
    end
    // Low byte alone with the upper domains still masked
    data = next_random_word();
    write_word(region_addr(2), PRIV, data, 4'b0001, RESP_OKAY);
    pol_model[2] = merge_strobed(pol_model[2], data, 4'b0001) & POLICY_MASK;
    check_all_regs();
  endtask

  task automatic test_unmapped();
    logic [CFG_ADDR_W-1:0] past_end;
    past_end = region_addr(TB_REGIONS);
    write_word(7'h04, PRIV, next_random_word(), 4'hF, RESP_SLVERR);
    write_word(past_end, PRIV, next_random_word(), 4'hF, RESP_SLVERR);
    read_word(7'h04, PRIV, RD_ERR_DATA, RESP_SLVERR);
    read_word(past_end, PRIV, RD_ERR_DATA, RESP_SLVERR);
    check_all_regs();
  endtask

  // Secure bit alone does not make an access privileged
  task automatic test_unprivileged();
    write_word(CTRL_OFFSET, 3'b000, next_random_word(), 4'hF, RESP_SLVERR);
    write_word(region_addr(1), 3'b010, next_random_word(), 4'hF, RESP_SLVERR);
    read_word(CTRL_OFFSET, 3'b000, RD_ERR_DATA, RESP_SLVERR);
    read_word(region_addr(0), 3'b110, RD_ERR_DATA, RESP_SLVERR);
    check_all_regs();
  endtask

  task automatic test_backpressure();
    logic [CFG_DATA_W-1:0] first_data;
    logic [CFG_DATA_W-1:0] second_data;
    first_data  = next_random_word();
    second_data = next_random_word();
    send_write(CTRL_OFFSET, PRIV, first_data, 4'hF);
    ctrl_model = first_data;
    // Second write waits behind the unread B response
    w_data_i   = second_data;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    repeat (4)
    begin
      #1;
      check_bit(b_valid_o, 1'b1, "b_valid_o under back-pressure");
      check_resp(b_resp_o, RESP_OKAY, "held b_resp_o");
      check_bit(aw_ready_o, 1'b0, "aw_ready_o while B slot is full");
      check_bit(w_ready_o, 1'b0, "w_ready_o while B slot is full");
      check_word(ctrl_o, first_data, "ctrl_o while second write waits");
      @(negedge clk_i);
    end
    b_ready_i = 1'b1;
    @(negedge clk_i);
    b_ready_i = 1'b0;
    write_word(CTRL_OFFSET, PRIV, second_data, 4'hF, RESP_OKAY);
    ctrl_model = second_data;
    check_word(ctrl_o, ctrl_model, "ctrl_o after released write");

    send_read(CTRL_OFFSET, PRIV);
    check_bit(r_valid_o, 1'b1, "r_valid_o one cycle after acceptance");
    check_word(r_data_o, second_data, "captured r_data_o");
    ar_addr_i  = region_addr(0);
    ar_valid_i = 1'b1;
    // Captured data must not follow a later write
    write_word(CTRL_OFFSET, PRIV, ~second_data, 4'hF, RESP_OKAY);
    ctrl_model = ~second_data;
    repeat (3)
    begin
      #1;
      check_bit(r_valid_o, 1'b1, "r_valid_o under back-pressure");
      check_bit(ar_ready_o, 1'b0, "ar_ready_o while R slot is full");
      check_word(r_data_o, second_data, "held r_data_o");
      check_resp(r_resp_o, RESP_OKAY, "held r_resp_o");
      @(negedge clk_i);
    end
    r_ready_i = 1'b1;
    @(negedge clk_i);
    r_ready_i = 1'b0;
    read_word(region_addr(0), PRIV, pol_model[0], RESP_OKAY);
    read_word(CTRL_OFFSET, PRIV, ctrl_model, RESP_OKAY);
  endtask

  initial
  begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_prot_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_prot_i  = '0;
    r_ready_i  = 1'b0;
    ctrl_model = '0;
    for (int r = 0; r < TB_REGIONS; r++)
      pol_model[r] = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    test_reset();
    test_ctrl_strobes();
    test_policy_writes();
    test_unmapped();
    test_unprivileged();
    test_backpressure();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: logic/protection_cfg_top.sv
`timescale 1ns/1ps

module protection_cfg_top #(
  parameter int unsigned NUM_REGIONS    = 2,
  parameter int unsigned NUM_DOMAINS    = 2,
  parameter bit          PRIV_PROT_ONLY = 1'b0,
  parameter bit          SECU_PROT_ONLY = 1'b0
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // AW and W channels
  input  logic                              aw_valid_i,
  output logic                              aw_ready_o,
  input  logic [pu_cfg_pkg::CFG_ADDR_W-1:0] aw_addr_i,
  input  logic [2:0]                        aw_prot_i,
  input  logic                              w_valid_i,
  output logic                              w_ready_o,
  input  logic [pu_cfg_pkg::CFG_DATA_W-1:0] w_data_i,
  input  logic [pu_cfg_pkg::CFG_STRB_W-1:0] w_strb_i,
  // B channel
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  output logic [1:0]                        b_resp_o,
  // AR channel
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [pu_cfg_pkg::CFG_ADDR_W-1:0] ar_addr_i,
  input  logic [2:0]                        ar_prot_i,
  // R channel
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [pu_cfg_pkg::CFG_DATA_W-1:0] r_data_o,
  output logic [1:0]                        r_resp_o,
  // Configuration outputs
  output logic [pu_cfg_pkg::CFG_DATA_W-1:0] ctrl_o,
  output pu_cfg_pkg::policy_entry_t [NUM_REGIONS-1:0][NUM_DOMAINS-1:0] policy_o
);

  reg_access_if #(.NUM_REGIONS(NUM_REGIONS)) cfg_bus ();

  cfg_write_channel #(
    .NUM_REGIONS    (NUM_REGIONS),
    .PRIV_PROT_ONLY (PRIV_PROT_ONLY),
    .SECU_PROT_ONLY (SECU_PROT_ONLY)
  ) u_wr_chan (
    .clk_i, .reset_i, .aw_valid_i, .aw_addr_i, .aw_prot_i, .w_valid_i, .w_data_i, .w_strb_i,
    .aw_ready_o, .w_ready_o, .b_valid_o, .b_resp_o, .b_ready_i,
    .bus (cfg_bus.wr_port)
  );

  cfg_read_channel #(
    .NUM_REGIONS    (NUM_REGIONS),
    .PRIV_PROT_ONLY (PRIV_PROT_ONLY),
    .SECU_PROT_ONLY (SECU_PROT_ONLY)
  ) u_rd_chan (
    .clk_i, .reset_i, .ar_valid_i, .ar_addr_i, .ar_prot_i,
    .ar_ready_o, .r_valid_o, .r_data_o, .r_resp_o, .r_ready_i,
    .bus (cfg_bus.rd_port)
  );

  policy_reg_file #(
    .NUM_REGIONS (NUM_REGIONS),
    .NUM_DOMAINS (NUM_DOMAINS)
  ) u_regs (
    .clk_i, .reset_i,
    .bus (cfg_bus.regs),
    .ctrl_o, .policy_o
  );

endmodule

// File: logic/policy_reg_file.sv
`timescale 1ns/1ps

module policy_reg_file #(
  parameter int unsigned NUM_REGIONS = 2,
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  reg_access_if.regs                                   bus,
  output logic [pu_cfg_pkg::CFG_DATA_W-1:0]            ctrl_o,
  output pu_cfg_pkg::policy_entry_t [NUM_REGIONS-1:0][NUM_DOMAINS-1:0] policy_o
);
  import pu_cfg_pkg::*;

  logic [CFG_DATA_W-1:0] ctrl_q;
  logic [CFG_DATA_W-1:0] ctrl_merged;
  policy_word_u          policy_q [NUM_REGIONS];
  policy_word_u          pol_merged;

  // Control word with strobed bytes replaced
  always_comb
  begin
    ctrl_merged = ctrl_q;
    for (int b = 0; b < CFG_STRB_W; b++)
    begin
      if (bus.wr_strb[b])
        ctrl_merged[8*b +: 8] = bus.wr_data[8*b +: 8];
    end
  end

  // Policy word merged by byte, then trimmed by domain
  always_comb
  begin
    pol_merged = policy_q[bus.wr_region];
    for (int b = 0; b < CFG_STRB_W; b++)
    begin
      if (bus.wr_strb[b])
        pol_merged.bytes[b] = bus.wr_data[8*b +: 8];
    end
    // Entries of domains that do not exist read back as zero
    for (int d = NUM_DOMAINS; d < MAX_DOMAINS; d++)
      pol_merged.entries[d] = '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      ctrl_q <= '0;
      for (int r = 0; r < NUM_REGIONS; r++)
        policy_q[r] <= '0;
    end
    else if (bus.wr_en)
    begin
      case (bus.wr_kind)
        KIND_CTRL:   ctrl_q <= ctrl_merged;
        KIND_POLICY: policy_q[bus.wr_region] <= pol_merged;
        default:     ;
      endcase
    end
  end

  // Read mux, unmapped kinds give zero and the channel substitutes the error word
  always_comb
  begin
    bus.rd_data = '0;
    case (bus.rd_kind)
      KIND_CTRL:   bus.rd_data = ctrl_q;
      KIND_POLICY: bus.rd_data = policy_q[bus.rd_region];
      default:     bus.rd_data = '0;
    endcase
  end

  assign ctrl_o = ctrl_q;

  // Only the configured domains leave the block
  for (genvar r = 0; r < NUM_REGIONS; r++)
  begin : gen_policy_out
    assign policy_o[r] = policy_q[r].entries[NUM_DOMAINS-1:0];
  end

  // Write decoder never grants a policy write past the last region
  assert property (@(posedge clk_i) disable iff (reset_i)
    (bus.wr_en && bus.wr_kind == KIND_POLICY) |-> (bus.wr_region < NUM_REGIONS));

endmodule

// File: logic/cfg_read_channel.sv
`timescale 1ns/1ps

module cfg_read_channel #(
  parameter int unsigned NUM_REGIONS    = 2,
  parameter bit          PRIV_PROT_ONLY = 1'b0,
  parameter bit          SECU_PROT_ONLY = 1'b0
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              ar_valid_i,
  input  logic [pu_cfg_pkg::CFG_ADDR_W-1:0] ar_addr_i,
  input  logic [2:0]                        ar_prot_i,
  output logic                              ar_ready_o,
  output logic                              r_valid_o,
  output logic [pu_cfg_pkg::CFG_DATA_W-1:0] r_data_o,
  output logic [1:0]                        r_resp_o,
  input  logic                              r_ready_i,
  reg_access_if.rd_port                     bus
);
  import pu_cfg_pkg::*;

  logic ready_en_q;
  logic slot_full_q;
  logic accept;
  logic dec_ok;

  cfg_addr_decoder #(
    .NUM_REGIONS    (NUM_REGIONS),
    .PRIV_PROT_ONLY (PRIV_PROT_ONLY),
    .SECU_PROT_ONLY (SECU_PROT_ONLY)
  ) u_ar_dec (
    .addr_i   (ar_addr_i),
    .prot_i   (ar_prot_i),
    .kind_o   (bus.rd_kind),
    .region_o (bus.rd_region),
    .ok_o     (dec_ok)
  );

  // Keeps ar_ready low through the first cycle after reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      ready_en_q <= 1'b0;
    else
      ready_en_q <= 1'b1;
  end

  assign ar_ready_o = ready_en_q && !slot_full_q;
  assign accept     = ar_ready_o && ar_valid_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      slot_full_q <= 1'b0;
    else if (accept)
      slot_full_q <= 1'b1;
    else if (r_ready_i)
      slot_full_q <= 1'b0;
  end

  // Data is sampled at acceptance, later writes do not leak in
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      r_data_o <= dec_ok ? bus.rd_data : RD_ERR_DATA;
      r_resp_o <= dec_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign r_valid_o = slot_full_q;

  // A waiting R beat keeps its payload until taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_data_o) && $stable(r_resp_o)));

endmodule

// File: logic/cfg_write_channel.sv
`timescale 1ns/1ps

module cfg_write_channel #(
  parameter int unsigned NUM_REGIONS    = 2,
  parameter bit          PRIV_PROT_ONLY = 1'b0,
  parameter bit          SECU_PROT_ONLY = 1'b0
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              aw_valid_i,
  input  logic [pu_cfg_pkg::CFG_ADDR_W-1:0] aw_addr_i,
  input  logic [2:0]                        aw_prot_i,
  input  logic                              w_valid_i,
  input  logic [pu_cfg_pkg::CFG_DATA_W-1:0] w_data_i,
  input  logic [pu_cfg_pkg::CFG_STRB_W-1:0] w_strb_i,
  output logic                              aw_ready_o,
  output logic                              w_ready_o,
  output logic                              b_valid_o,
  output logic [1:0]                        b_resp_o,
  input  logic                              b_ready_i,
  reg_access_if.wr_port                     bus
);
  import pu_cfg_pkg::*;

  logic ready_en_q;
  logic slot_full_q;
  logic accept;
  logic dec_ok;

  cfg_addr_decoder #(
    .NUM_REGIONS    (NUM_REGIONS),
    .PRIV_PROT_ONLY (PRIV_PROT_ONLY),
    .SECU_PROT_ONLY (SECU_PROT_ONLY)
  ) u_aw_dec (
    .addr_i   (aw_addr_i),
    .prot_i   (aw_prot_i),
    .kind_o   (bus.wr_kind),
    .region_o (bus.wr_region),
    .ok_o     (dec_ok)
  );

  // Readies come up one edge after reset is released
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      ready_en_q <= 1'b0;
    else
      ready_en_q <= 1'b1;
  end

  // Address and data are taken together, only into an empty slot
  assign accept     = ready_en_q && !slot_full_q && aw_valid_i && w_valid_i;
  assign aw_ready_o = accept;
  assign w_ready_o  = accept;

  // Registers only see permitted writes to mapped words
  assign bus.wr_en   = accept && dec_ok;
  assign bus.wr_strb = w_strb_i;
  assign bus.wr_data = w_data_i;

  // Slot fills on accept, empties when the master takes B
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      slot_full_q <= 1'b0;
    else if (accept)
      slot_full_q <= 1'b1;
    else if (b_ready_i)
      slot_full_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      b_resp_o <= dec_ok ? RESP_OKAY : RESP_SLVERR;
  end

  assign b_valid_o = slot_full_q;

  // Held B response must not move under back-pressure
  assert property (@(posedge clk_i) disable iff (reset_i)
    (b_valid_o && !b_ready_i) |=> (b_valid_o && $stable(b_resp_o)));

endmodule

// File: logic/cfg_addr_decoder.sv
`timescale 1ns/1ps

module cfg_addr_decoder #(
  parameter int unsigned NUM_REGIONS    = 2,
  parameter bit          PRIV_PROT_ONLY = 1'b0,
  parameter bit          SECU_PROT_ONLY = 1'b0,
  localparam int unsigned REGION_W      = (NUM_REGIONS > 1) ? $clog2(NUM_REGIONS) : 1
) (
  input  logic [pu_cfg_pkg::CFG_ADDR_W-1:0] addr_i,
  input  logic [2:0]                        prot_i,
  output pu_cfg_pkg::reg_kind_e             kind_o,
  output logic [REGION_W-1:0]               region_o,
  output logic                              ok_o
);
  import pu_cfg_pkg::*;

  // Word index, the byte lanes are not part of the decode
  localparam int unsigned WORD_W = CFG_ADDR_W - 2;

  logic [WORD_W-1:0] word_idx;
  logic [WORD_W-1:0] pol_off;
  logic              ctrl_hit;
  logic              policy_hit;
  logic              prot_ok;

  assign word_idx = addr_i[CFG_ADDR_W-1:2];
  // Offset in words from policy word 0
  assign pol_off  = word_idx - POLICY_BASE[CFG_ADDR_W-1:2];

  assign ctrl_hit   = (word_idx == CTRL_OFFSET[CFG_ADDR_W-1:2]);
  assign policy_hit = (word_idx >= POLICY_BASE[CFG_ADDR_W-1:2]) &&
                      (pol_off < WORD_W'(NUM_REGIONS));

  // Privileged needs prot[0], secure needs prot[1]
  assign prot_ok = (!PRIV_PROT_ONLY || prot_i[0]) && (!SECU_PROT_ONLY || prot_i[1]);

  always_comb
  begin
    kind_o = KIND_NONE;
    if (ctrl_hit)
      kind_o = KIND_CTRL;
    else if (policy_hit)
      kind_o = KIND_POLICY;
  end

  assign region_o = pol_off[REGION_W-1:0];
  assign ok_o     = (kind_o != KIND_NONE) && prot_ok;

endmodule

// File: logic/reg_access_if.sv
`timescale 1ns/1ps

interface reg_access_if #(
  parameter int unsigned NUM_REGIONS = 2
);
  import pu_cfg_pkg::*;

  localparam int unsigned REGION_W = (NUM_REGIONS > 1) ? $clog2(NUM_REGIONS) : 1;

  // Write side, one strobe per granted write
  logic                  wr_en;
  reg_kind_e             wr_kind;
  logic [REGION_W-1:0]   wr_region;
  logic [CFG_STRB_W-1:0] wr_strb;
  logic [CFG_DATA_W-1:0] wr_data;

  // Read side, data comes back in the same cycle
  reg_kind_e             rd_kind;
  logic [REGION_W-1:0]   rd_region;
  logic [CFG_DATA_W-1:0] rd_data;

  modport wr_port (output wr_en, wr_kind, wr_region, wr_strb, wr_data);
  modport rd_port (output rd_kind, rd_region, input rd_data);
  modport regs (
    input  wr_en, wr_kind, wr_region, wr_strb, wr_data, rd_kind, rd_region,
    output rd_data
  );

endinterface

// File: logic/pu_cfg_pkg.sv
package pu_cfg_pkg;

  // Bus geometry, only the low address bits are decoded
  localparam int unsigned CFG_ADDR_W  = 7;
  localparam int unsigned CFG_DATA_W  = 32;
  localparam int unsigned CFG_STRB_W  = CFG_DATA_W / 8;

  // Two bits per domain fill one 32-bit policy word
  localparam int unsigned MAX_DOMAINS = 16;

  // Register map
  localparam logic [CFG_ADDR_W-1:0] CTRL_OFFSET = 7'h00;
  localparam logic [CFG_ADDR_W-1:0] POLICY_BASE = 7'h40;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Returned on every rejected read
  localparam logic [CFG_DATA_W-1:0] RD_ERR_DATA = 32'hBA5E_1E55;

  // Which register an address selects
  typedef enum logic [1:0] {
    KIND_NONE   = 2'd0,
    KIND_CTRL   = 2'd1,
    KIND_POLICY = 2'd2
  } reg_kind_e;

  // Access rights of one domain, read above write
  typedef struct packed {
    logic rd;
    logic wr;
  } policy_entry_t;

  // One policy word seen as bus bytes or as per-domain entries
  typedef union packed {
    logic [CFG_STRB_W-1:0][7:0]        bytes;
    policy_entry_t [MAX_DOMAINS-1:0]   entries;
  } policy_word_u;

endpackage
